/* Makefile */
TOOL      = verilator
FLAGS     = --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP       = tb_cu_sum_kernel
FILE_LIST = build.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_TEXT = *** TEST PASSED ***

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* build.f */
+incdir+.
sum_kernel_pkg.sv
sync_fifo.sv
sum_edge_combine.sv
nlock_retry_queue.sv
sum_kernel_control.sv
cu_sum_kernel.sv
tb_cu_sum_kernel.sv

/* cu_sum_kernel.sv */
// compute unit top joining the edge input buffer and the kernel control
`include "sum_kernel_defs.svh"

module cu_sum_kernel #(
	parameter sum_kernel_pkg::cu_id_t CU_ID = '0
) (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           enabled_in,
	input  sum_kernel_pkg::vertex_job_t    vertex_job,
	input  sum_kernel_pkg::edge_data_t     edge_in,
	input  sum_kernel_pkg::buffer_status_t write_buffer_status,
	input  logic                           write_grant,
	input  sum_kernel_pkg::write_resp_t    write_resp,
	output logic                           edge_full,
	output logic                           write_request,
	output sum_kernel_pkg::edge_write_t    edge_write_out,
	output sum_kernel_pkg::edge_index_t    edge_response_count,
	output sum_kernel_pkg::vertex_count_t  vertex_count,
	output sum_kernel_pkg::edge_index_t    vertex_edge_total
);

	import sum_kernel_pkg::*;

	buffer_status_t edge_fifo_status;
	edge_data_t     edge_data;
	logic           edge_request;

	assign edge_full = edge_fifo_status.full;

	// host pushes on every valid edge item
	sync_fifo #(
		.WIDTH($bits(edge_data_t)),
		.DEPTH(`SK_EDGE_FIFO_DEPTH)
	) i_edge_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (edge_in.valid),
		.data_in (edge_in),
		.pop     (edge_request),
		.data_out(edge_data),
		.full    (edge_fifo_status.full),
		.alfull  (edge_fifo_status.alfull),
		.empty   (edge_fifo_status.empty),
		.valid   (edge_fifo_status.valid)
	);

	sum_kernel_control #(.CU_ID(CU_ID)) i_control (
		.clock              (clock),
		.rstn               (rstn),
		.enabled_in         (enabled_in),
		.vertex_job         (vertex_job),
		.write_resp         (write_resp),
		.write_buffer_status(write_buffer_status),
		.edge_fifo_status   (edge_fifo_status),
		.edge_data          (edge_data),
		.write_grant        (write_grant),
		.edge_request       (edge_request),
		.write_request      (write_request),
		.edge_write_out     (edge_write_out),
		.edge_response_count(edge_response_count),
		.vertex_count       (vertex_count),
		.vertex_edge_total  (vertex_edge_total)
	);

endmodule

/* nlock_retry_queue.sv */
// holds writes refused with a lock response until they can be issued again
`include "sum_kernel_defs.svh"

module nlock_retry_queue #(
	parameter sum_kernel_pkg::cu_id_t CU_ID = '0
) (
	input  logic                        clock,
	input  logic                        rstn,
	input  sum_kernel_pkg::write_resp_t write_resp,
	input  logic                        retry_take,
	output sum_kernel_pkg::edge_write_t retry_out,
	output logic                        retry_pending
);

	import sum_kernel_pkg::*;

	edge_write_t nlock_latched;

	// rebuild the refused write from the response
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			nlock_latched <= '0;
		end else if (write_resp.valid && write_resp.code == `SK_RESP_NLOCK) begin
			nlock_latched.valid <= 1'b1;
			nlock_latched.index <= write_resp.index;
			nlock_latched.cu_id <= CU_ID;
			nlock_latched.data  <= write_resp.data;
		end else begin
			nlock_latched <= '0;
		end
	end

	// head is offered while pending, retry_take pops it
	sync_fifo #(
		.WIDTH($bits(edge_write_t)),
		.DEPTH(`SK_WRITE_FIFO_DEPTH)
	) i_retry_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (nlock_latched.valid),
		.data_in (nlock_latched),
		.pop     (retry_take),
		.data_out(retry_out),
		.full    (),
		.alfull  (),
		.empty   (),
		.valid   (retry_pending)
	);

endmodule

/* sum_edge_combine.sv */
// three stage pipeline adding the vertex value to each edge value
module sum_edge_combine #(
	parameter sum_kernel_pkg::cu_id_t CU_ID = '0
) (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled,
	input  sum_kernel_pkg::vertex_job_t vertex_job,
	input  sum_kernel_pkg::edge_data_t  edge_data,
	output sum_kernel_pkg::edge_write_t sum_out
);

	import sum_kernel_pkg::*;

	vertex_job_t job_latched;
	edge_data_t  edge_latched;
	logic        operand_valid;
	value_t      operand_a;
	value_t      operand_b;
	edge_index_t dest_index;

	//////////////////////////////
	// stage 1 latch job and edge
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_latched  <= '0;
			edge_latched <= '0;
		end else if (enabled) begin
			job_latched <= vertex_job;
			if (edge_data.valid) begin
				edge_latched <= edge_data;
			end else begin
				edge_latched <= '0;
			end
		end
	end

	//////////////////////////////
	// stage 2 operands
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			operand_valid <= 1'b0;
		end else if (enabled) begin
			operand_valid <= edge_latched.valid;
		end
	end

	always_ff @(posedge clock) begin
		if (enabled && edge_latched.valid) begin
			operand_a  <= job_latched.value;
			operand_b  <= edge_latched.value;
			dest_index <= edge_latched.index;
		end
	end

	//////////////////////////////
	// stage 3 tagged sum
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			sum_out <= '0;
		end else if (enabled) begin
			sum_out.valid <= operand_valid;
			sum_out.index <= dest_index;
			sum_out.cu_id <= CU_ID;
			sum_out.data  <= operand_a + operand_b;
		end else begin
			// frozen stages keep their items for later
			sum_out <= '0;
		end
	end

endmodule

/* sum_kernel_control.sv */
// kernel control merging sums and retries into the write buffer and keeping counts
`include "sum_kernel_defs.svh"

module sum_kernel_control #(
	parameter sum_kernel_pkg::cu_id_t CU_ID = '0
) (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           enabled_in,
	input  sum_kernel_pkg::vertex_job_t    vertex_job,
	input  sum_kernel_pkg::write_resp_t    write_resp,
	input  sum_kernel_pkg::buffer_status_t write_buffer_status,
	input  sum_kernel_pkg::buffer_status_t edge_fifo_status,
	input  sum_kernel_pkg::edge_data_t     edge_data,
	input  logic                           write_grant,
	output logic                           edge_request,
	output logic                           write_request,
	output sum_kernel_pkg::edge_write_t    edge_write_out,
	output sum_kernel_pkg::edge_index_t    edge_response_count,
	output sum_kernel_pkg::vertex_count_t  vertex_count,
	output sum_kernel_pkg::edge_index_t    vertex_edge_total
);

	import sum_kernel_pkg::*;

	localparam int LEVEL_BITS = $clog2(`SK_WRITE_FIFO_DEPTH) + 2;
	localparam logic [LEVEL_BITS-1:0] LEVEL_LIMIT =
		LEVEL_BITS'(`SK_WRITE_FIFO_DEPTH - `SK_ALFULL_MARGIN);

	logic                  enabled;
	vertex_job_t           vertex_job_latched;
	write_resp_t           write_resp_latched;
	buffer_status_t        edge_status_latched;
	edge_data_t            edge_popped;
	edge_write_t           sum_out;
	edge_write_t           retry_out;
	logic                  retry_pending;
	logic                  retry_take;
	edge_write_t           write_issue;
	edge_write_t           write_head;
	buffer_status_t        write_fifo_status;
	logic                  write_grant_latched;
	logic                  write_pop;
	logic [LEVEL_BITS-1:0] write_level;
	logic [LEVEL_BITS-1:0] write_level_next;
	logic                  edge_done;
	logic                  new_vertex;
	edge_index_t           vertex_edge_count;
	logic [3:0]            settle_count;

	//////////////////////////////
	// enable and input latches
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled             <= 1'b0;
			vertex_job_latched  <= '0;
			write_resp_latched  <= '0;
			edge_status_latched <= '{full: 1'b0, alfull: 1'b0, empty: 1'b1, valid: 1'b0};
		end else begin
			enabled <= enabled_in;
			if (enabled) begin
				vertex_job_latched  <= vertex_job;
				write_resp_latched  <= write_resp;
				edge_status_latched <= edge_fifo_status;
			end
		end
	end

	// only a real pop from a non-empty edge fifo enters the pipeline
	always_comb begin
		edge_popped       = edge_data;
		edge_popped.valid = edge_data.valid && edge_request && edge_fifo_status.valid;
	end

	sum_edge_combine #(.CU_ID(CU_ID)) i_combine (
		.clock     (clock),
		.rstn      (rstn),
		.enabled   (enabled),
		.vertex_job(vertex_job),
		.edge_data (edge_popped),
		.sum_out   (sum_out)
	);

	nlock_retry_queue #(.CU_ID(CU_ID)) i_retry (
		.clock        (clock),
		.rstn         (rstn),
		.write_resp   (write_resp),
		.retry_take   (retry_take),
		.retry_out    (retry_out),
		.retry_pending(retry_pending)
	);

	//////////////////////////////
	// write issue and buffer
	//////////////////////////////

	// write level counts queued entries plus those still in the pipe
	assign write_pop        = write_grant_latched && write_fifo_status.valid;
	assign write_level_next = write_level + LEVEL_BITS'(edge_popped.valid)
		+ LEVEL_BITS'(retry_take) - LEVEL_BITS'(write_pop);

	// a fresh sum always wins the issue slot
	assign retry_take = retry_pending && !sum_out.valid && !(write_level > LEVEL_LIMIT);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_issue <= '0;
		end else begin
			write_issue <= retry_take ? retry_out : sum_out;
		end
	end

	sync_fifo #(
		.WIDTH($bits(edge_write_t)),
		.DEPTH(`SK_WRITE_FIFO_DEPTH)
	) i_write_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (write_issue.valid),
		.data_in (write_issue),
		.pop     (write_pop),
		.data_out(write_head),
		.full    (write_fifo_status.full),
		.alfull  (write_fifo_status.alfull),
		.empty   (write_fifo_status.empty),
		.valid   (write_fifo_status.valid)
	);

	// edge_request taken from enabled_in so a pop never meets a frozen pipeline
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_level         <= '0;
			edge_request        <= 1'b0;
			write_request       <= 1'b0;
			write_grant_latched <= 1'b0;
			edge_write_out      <= '0;
		end else begin
			write_level         <= write_level_next;
			edge_request        <= enabled_in && !edge_status_latched.empty &&
				!(write_level_next > LEVEL_LIMIT);
			write_request       <= !write_fifo_status.empty && !write_buffer_status.alfull &&
				!retry_pending;
			write_grant_latched <= write_grant;
			edge_write_out      <= write_pop ? write_head : '0;
		end
	end

	//////////////////////////////
	// counters
	//////////////////////////////

	assign edge_done = write_resp_latched.valid && write_resp_latched.code != `SK_RESP_NLOCK;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_response_count <= '0;
			vertex_count        <= '0;
			new_vertex          <= 1'b0;
			vertex_edge_count   <= '0;
			vertex_edge_total   <= '0;
			settle_count        <= '0;
		end else if (enabled) begin
			if (edge_done) begin
				edge_response_count <= edge_response_count + 1'b1;
			end
			// one count per rise of the job valid
			if (vertex_job_latched.valid && !new_vertex) begin
				new_vertex   <= 1'b1;
				vertex_count <= vertex_count + 1'b1;
			end else if (!vertex_job_latched.valid) begin
				new_vertex <= 1'b0;
			end
			if (vertex_job_latched.valid) begin
				if (vertex_edge_count == vertex_job_latched.out_degree) begin
					// publish once the count has held for the settle window
					if (settle_count == `SK_SETTLE_CYCLES) begin
						vertex_edge_total <= vertex_edge_count;
						vertex_edge_count <= '0;
						settle_count      <= '0;
					end else begin
						settle_count <= settle_count + 1'b1;
					end
				end else begin
					settle_count <= '0;
					if (edge_done) begin
						vertex_edge_count <= vertex_edge_count + 1'b1;
					end
				end
			end
		end
	end

endmodule

/* sum_kernel_defs.svh */
// widths, buffer depths, response codes and settle window of the sum kernel
`ifndef SUM_KERNEL_DEFS_SVH
`define SUM_KERNEL_DEFS_SVH

// datapath widths
`define SK_VERTEX_BITS 32
`define SK_EDGE_BITS 32
`define SK_DATA_BITS 32
`define SK_CU_ID_BITS 8

// buffer sizes
`define SK_EDGE_FIFO_DEPTH 16
`define SK_WRITE_FIFO_DEPTH 16

// free entries still left when almost full rises
`define SK_ALFULL_MARGIN 4

// last count of the 16 cycle settle window
`define SK_SETTLE_CYCLES 4'd15

// write response codes
`define SK_RESP_DONE 2'b01
`define SK_RESP_NLOCK 2'b10

`endif

/* sum_kernel_pkg.sv */
// types and bundles shared across the sum kernel compute unit
`include "sum_kernel_defs.svh"

package sum_kernel_pkg;

	typedef logic [`SK_VERTEX_BITS-1:0] vertex_count_t;
	typedef logic [`SK_EDGE_BITS-1:0] edge_index_t;
	typedef logic [`SK_DATA_BITS-1:0] value_t;
	typedef logic [`SK_CU_ID_BITS-1:0] cu_id_t;
	typedef logic [1:0] resp_code_t;

	// held by the host for the whole job
	typedef struct packed {
		logic valid;
		value_t value;
		edge_index_t out_degree;
	} vertex_job_t;

	typedef struct packed {
		logic valid;
		edge_index_t index;
		value_t value;
	} edge_data_t;

	// one write toward the shared bus
	typedef struct packed {
		logic valid;
		edge_index_t index;
		cu_id_t cu_id;
		value_t data;
	} edge_write_t;

	typedef struct packed {
		logic valid;
		resp_code_t code;
		edge_index_t index;
		value_t data;
	} write_resp_t;

	typedef struct packed {
		logic full;
		logic alfull;
		logic empty;
		logic valid;
	} buffer_status_t;

endpackage

/* sync_fifo.sv */
// synchronous fifo with the head entry always visible on the output
`include "sum_kernel_defs.svh"

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             alfull,
	output logic             empty,
	output logic             valid
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]    mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                do_push;
	logic                do_pop;

	// pushes into a full fifo and pops from an empty one are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_BITS'(do_push) - CNT_BITS'(do_pop);
		end
	end

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	assign data_out = mem[rd_ptr];
	assign full     = (count == CNT_BITS'(DEPTH));
	// fewer than the margin left free
	assign alfull   = (count > CNT_BITS'(DEPTH - `SK_ALFULL_MARGIN));
	assign empty    = (count == '0);
	assign valid    = !empty;

endmodule

/* tb_cu_sum_kernel.sv */
// directed testbench for the sum kernel compute unit
`include "sum_kernel_defs.svh"

module tb_cu_sum_kernel;

	timeunit 1ns;
	timeprecision 1ps;

	import sum_kernel_pkg::*;

	localparam cu_id_t CU_ID = 8'd5;
	localparam int EDGES_PER_JOB = 20;
	localparam int BACKPRESSURE_EDGES = 40;
	// reset, sum path, completion, retry, back-pressure, enable
	localparam int TEST_BUDGET = 100 + 300 + 300 + 200 + 700 + 400;
	localparam int TIMEOUT_CYCLES = 2 * TEST_BUDGET;

	logic           clock;
	logic           rstn;
	logic           enabled_in;
	vertex_job_t    vertex_job;
	edge_data_t     edge_in;
	buffer_status_t write_buffer_status;
	logic           write_grant;
	write_resp_t    write_resp;
	logic           edge_full;
	logic           write_request;
	edge_write_t    edge_write_out;
	edge_index_t    edge_response_count;
	vertex_count_t  vertex_count;
	edge_index_t    vertex_edge_total;

	edge_write_t expected_writes[$];
	value_t      vertex_value;
	int          seed;
	int          error_count;
	int          check_count;
	int          cycle_count = 0;

	cu_sum_kernel #(.CU_ID(CU_ID)) i_dut (
		.clock              (clock),
		.rstn               (rstn),
		.enabled_in         (enabled_in),
		.vertex_job         (vertex_job),
		.edge_in            (edge_in),
		.write_buffer_status(write_buffer_status),
		.write_grant        (write_grant),
		.write_resp         (write_resp),
		.edge_full          (edge_full),
		.write_request      (write_request),
		.edge_write_out     (edge_write_out),
		.edge_response_count(edge_response_count),
		.vertex_count       (vertex_count),
		.vertex_edge_total  (vertex_edge_total)
	);

	initial clock = 1'b0;

	always #10 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("run stopped after %0d cycles before the tests finished", cycle_count);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	//////////////////////////////
	// checking and model
	//////////////////////////////

	task automatic check_value(input string name, input logic [127:0] actual,
		input logic [127:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("MISMATCH %s actual 0x%0h expected 0x%0h at cycle %0d",
				name, actual, expected, cycle_count);
		end
	endtask

	task automatic report_error(input string text);
		error_count++;
		$display("ERROR %s at cycle %0d", text, cycle_count);
	endtask

	function automatic edge_write_t expected_write(input edge_index_t index, input value_t data);
		edge_write_t result;
		result.valid = 1'b1;
		result.index = index;
		result.cu_id = CU_ID;
		result.data  = data;
		return result;
	endfunction

	task automatic check_idle_outputs();
		check_value("write_request", write_request, 1'b0);
		check_value("edge_full", edge_full, 1'b0);
		check_value("edge_write_out.valid", edge_write_out.valid, 1'b0);
		check_value("edge_response_count", edge_response_count, 0);
		check_value("vertex_count", vertex_count, 0);
		check_value("vertex_edge_total", vertex_edge_total, 0);
	endtask

	//////////////////////////////
	// stimulus helpers
	//////////////////////////////

	// one push every other cycle so edge_full is always current
	task automatic push_edge(input edge_index_t index, input value_t value);
		@(posedge clock);
		while (edge_full) begin
			@(posedge clock);
		end
		edge_in <= '{valid: 1'b1, index: index, value: value};
		expected_writes.push_back(expected_write(index, vertex_value + value));
		@(posedge clock);
		edge_in <= '0;
	endtask

	task automatic push_random_edges(input int count);
		edge_index_t index;
		value_t      value;
		repeat (count) begin
			index = $random(seed);
			value = $random(seed);
			push_edge(index, value);
		end
	endtask

	// grant while requested and match each write against the model
	task automatic collect_writes(input int count);
		int          seen;
		edge_write_t expected;
		seen = 0;
		while (seen < count) begin
			@(posedge clock);
			write_grant <= write_request;
			if (edge_write_out.valid) begin
				if (expected_writes.size() == 0) begin
					report_error("write arrived while none was expected");
				end else begin
					expected = expected_writes.pop_front();
					check_value("edge_write_out", edge_write_out, expected);
				end
				seen++;
			end
		end
		write_grant <= 1'b0;
	endtask

	task automatic expect_quiet(input int cycles);
		repeat (cycles) begin
			@(posedge clock);
			write_grant <= write_request;
			if (edge_write_out.valid) begin
				report_error("write arrived during a quiet window");
			end
		end
		write_grant <= 1'b0;
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////

	task automatic test_reset();
		repeat (8) @(posedge clock);
		check_idle_outputs();
		repeat (8) @(posedge clock);
		rstn <= 1'b1;
		enabled_in <= 1'b1;
		repeat (2) @(posedge clock);
		check_idle_outputs();
	endtask

	task automatic test_sum_path();
		vertex_value = $random(seed);
		vertex_job <= '{valid: 1'b1, value: vertex_value,
			out_degree: edge_index_t'(EDGES_PER_JOB)};
		fork
			push_random_edges(EDGES_PER_JOB);
			collect_writes(EDGES_PER_JOB);
		join
		// no write trails the twentieth
		expect_quiet(30);
		check_value("vertex_count", vertex_count, 1);
	endtask

	task automatic test_completion();
		int i;
		int waited;
		for (i = 0; i < EDGES_PER_JOB; i++) begin
			@(posedge clock);
			write_resp <= '{valid: 1'b1, code: `SK_RESP_DONE,
				index: edge_index_t'(i), data: value_t'(i)};
		end
		@(posedge clock);
		write_resp <= '0;
		while (edge_response_count != EDGES_PER_JOB) begin
			@(posedge clock);
		end
		// total waits out the settle window
		check_value("vertex_edge_total", vertex_edge_total, 0);
		waited = 0;
		while (vertex_edge_total != EDGES_PER_JOB && waited < 40) begin
			@(posedge clock);
			waited++;
		end
		check_value("settle cycles", waited, 16);
		check_value("vertex_edge_total", vertex_edge_total, EDGES_PER_JOB);
		check_value("edge_response_count", edge_response_count, EDGES_PER_JOB);
	endtask

	task automatic test_retry();
		int          i;
		edge_index_t index;
		value_t      data;
		for (i = 0; i < 3; i++) begin
			index = 32'h0000_0a11 + 32'h111 * i;
			data  = 32'hcafe_0000 + i;
			@(posedge clock);
			write_resp <= '{valid: 1'b1, code: `SK_RESP_NLOCK, index: index, data: data};
			expected_writes.push_back(expected_write(index, data));
		end
		@(posedge clock);
		write_resp <= '0;
		collect_writes(3);
		check_value("edge_response_count", edge_response_count, EDGES_PER_JOB);
	endtask

	task automatic test_backpressure();
		write_buffer_status <= '{full: 1'b0, alfull: 1'b1, empty: 1'b0, valid: 1'b1};
		fork
			push_random_edges(BACKPRESSURE_EDGES);
			begin
				while (!edge_full) begin
					@(posedge clock);
				end
				repeat (10) begin
					@(posedge clock);
					check_value("write_request", write_request, 1'b0);
				end
				write_buffer_status <= '0;
				collect_writes(BACKPRESSURE_EDGES);
			end
		join
		// nothing duplicated after the drain
		expect_quiet(30);
	endtask

	task automatic test_enable_jobs();
		vertex_count_t start_count;
		enabled_in <= 1'b0;
		repeat (2) @(posedge clock);
		push_random_edges(4);
		expect_quiet(20);
		enabled_in <= 1'b1;
		collect_writes(4);
		start_count = vertex_count;
		repeat (2) begin
			@(posedge clock);
			vertex_job.valid <= 1'b0;
			repeat (4) @(posedge clock);
			vertex_job.valid <= 1'b1;
			repeat (4) @(posedge clock);
		end
		check_value("vertex_count", vertex_count, start_count + 2);
	endtask

	initial begin
		seed        = 32'h3f5d_f9e6;
		error_count = 0;
		check_count = 0;
		rstn                <= 1'b0;
		enabled_in          <= 1'b0;
		vertex_job          <= '0;
		edge_in             <= '0;
		write_buffer_status <= '0;
		write_grant         <= 1'b0;
		write_resp          <= '0;
		test_reset();
		test_sum_path();
		test_completion();
		test_retry();
		test_backpressure();
		test_enable_jobs();
		$display("checks run %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
